// File: hw/cpuPkg.sv
package cpuPkg;

	//////////////////////////////////////////////////////////////////////
	// Data path widths
	//////////////////////////////////////////////////////////////////////

	// Integer data path
	localparam int DataWidth = 32;
	// GPR address, also the shift amount field
	localparam int RegAddrWidth = 5;
	// Tuse and Tnew hazard counts
	localparam int HazardCountWidth = 3;

	//////////////////////////////////////////////////////////////////////
	// Reset constants
	//////////////////////////////////////////////////////////////////////

	// PC held in EX/Mem after reset, start of the text segment
	localparam logic [DataWidth-1:0] ResetPc = 32'h0000_3000;
	// Tuse meaning "operand never read"
	localparam logic [HazardCountWidth-1:0] TuseIdle = 3'd7;

	//////////////////////////////////////////////////////////////////////
	// Multiply / divide timing
	//////////////////////////////////////////////////////////////////////

	// Busy edges after the start edge
	localparam int MultCycles = 5;
	localparam int DivCycles = 10;
	// Counter wide enough for the longer of the two
	localparam int CycleCountWidth = 4;

	//////////////////////////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////////////////////////

	// Operations that matter to the execute stage
	typedef enum logic [4:0] {
		opNop,
		opAddu,
		opSubu,
		opAnd,
		opOr,
		opXor,
		opNor,
		opSlt,
		opSltu,
		opSll,
		opSrl,
		opSra,
		opSllv,
		opLui,
		opOri,
		opAddiu,
		opLw,
		opSw,
		opMult,
		opMultu,
		opDiv,
		opDivu,
		opMfhi,
		opMflo,
		opMthi,
		opMtlo,
		opLink
	} opcodeT;

	// Operand source chosen by the hazard unit
	typedef enum logic [1:0] {
		fwdRegFile = 2'd0,
		fwdEx      = 2'd1,
		fwdMem     = 2'd2
	} fwdSelT;

endpackage

// File: hw/operandForward.sv
`timescale 1ns/100ps

module operandForward import cpuPkg::*;
(
	input  logic [DataWidth-1:0]        rsData,
	input  logic [DataWidth-1:0]        rtData,
	input  logic [DataWidth-1:0]        bypassEx,
	input  logic [DataWidth-1:0]        bypassMem,
	input  logic [DataWidth-1:0]        imm32,
	input  fwdSelT                      rsFwdSel,
	input  fwdSelT                      rtFwdSel,
	input  opcodeT                      opcode,
	input  logic [HazardCountWidth-1:0] tuseRs,
	input  logic [HazardCountWidth-1:0] tuseRt,
	input  logic [HazardCountWidth-1:0] tnew,
	output logic [DataWidth-1:0]        operandA,
	output logic [DataWidth-1:0]        operandB,
	output logic [DataWidth-1:0]        storeData,
	output logic [HazardCountWidth-1:0] tuseRsDec,
	output logic [HazardCountWidth-1:0] tuseRtDec,
	output logic [HazardCountWidth-1:0] tnewDec
);

	// Register value or one of the two bypass paths
	function automatic logic [DataWidth-1:0] pickSource(
		input fwdSelT               sel,
		input logic [DataWidth-1:0] regValue,
		input logic [DataWidth-1:0] exValue,
		input logic [DataWidth-1:0] memValue
	);
		case (sel)
			fwdEx:   return exValue;
			fwdMem:  return memValue;
			default: return regValue;
		endcase
	endfunction

	// One stage closer, saturating at zero
	function automatic logic [HazardCountWidth-1:0] countDown(
		input logic [HazardCountWidth-1:0] count
	);
		if (count != '0)
			return count - 1'b1;
		else
			return count;
	endfunction

	logic [DataWidth-1:0] rtForwarded;
	logic                 useImm;

	//////////////////////////////////////////////////////////////////////
	// Operand muxes
	//////////////////////////////////////////////////////////////////////

	assign operandA    = pickSource(rsFwdSel, rsData, bypassEx, bypassMem);
	assign rtForwarded = pickSource(rtFwdSel, rtData, bypassEx, bypassMem);

	// I-type ops take the immediate as second operand
	assign useImm   = opcode inside {opOri, opAddiu, opLui, opLw, opSw};
	assign operandB = useImm ? imm32 : rtForwarded;

	// Store data bypasses the immediate substitution
	assign storeData = rtForwarded;

	// Counts as seen one stage later
	assign tuseRsDec = countDown(tuseRs);
	assign tuseRtDec = countDown(tuseRt);
	assign tnewDec   = countDown(tnew);

	// Encoding 2'b11 is never a legal select
	always_comb
	begin
		assert ($isunknown(rsFwdSel) || rsFwdSel inside {fwdRegFile, fwdEx, fwdMem})
			else $error("operandForward: illegal rsFwdSel %0d", rsFwdSel);
		assert ($isunknown(rtFwdSel) || rtFwdSel inside {fwdRegFile, fwdEx, fwdMem})
			else $error("operandForward: illegal rtFwdSel %0d", rtFwdSel);
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/100ps

module alu import cpuPkg::*;
(
	input  opcodeT                  opcode,
	input  logic [DataWidth-1:0]    operandA,
	input  logic [DataWidth-1:0]    operandB,
	input  logic [RegAddrWidth-1:0] shamt,
	output logic [DataWidth-1:0]    aluResult
);

	logic [DataWidth-1:0]    sum;
	logic [DataWidth-1:0]    difference;
	logic                    lessSigned;
	logic                    lessUnsigned;
	logic [RegAddrWidth-1:0] varShift;

	//////////////////////////////////////////////////////////////////////
	// Shared arithmetic
	//////////////////////////////////////////////////////////////////////

	// Wrapping add, also the load/store address
	assign sum        = operandA + operandB;
	// Wrapping subtract, no overflow trap
	assign difference = operandA - operandB;

	// Compares for slt and sltu
	assign lessSigned   = $signed(operandA) < $signed(operandB);
	assign lessUnsigned = operandA < operandB;

	// Variable shift distance from rs
	assign varShift = operandA[RegAddrWidth-1:0];

	//////////////////////////////////////////////////////////////////////
	// Result by opcode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			opAddu,
			opAddiu,
			opLw,
			opSw:
				aluResult = sum;
			opSubu:
				aluResult = difference;

			// Bitwise group
			opAnd:
				aluResult = operandA & operandB;
			opOr,
			opOri:
				aluResult = operandA | operandB;
			opXor:
				aluResult = operandA ^ operandB;
			opNor:
				aluResult = ~(operandA | operandB);

			// Set on less than, flag in bit 0
			opSlt:
				aluResult = {{(DataWidth-1){1'b0}}, lessSigned};
			opSltu:
				aluResult = {{(DataWidth-1){1'b0}}, lessUnsigned};

			// Shifts act on rt
			opSll:
				aluResult = operandB << shamt;
			opSrl:
				aluResult = operandB >> shamt;
			opSra:
				aluResult = $signed(operandB) >>> shamt;
			opSllv:
				aluResult = operandB << varShift;

			// Immediate low half into the upper half
			opLui:
				aluResult = {operandB[DataWidth/2-1:0], {(DataWidth/2){1'b0}}};

			// HI/LO moves, link and nop
			default:
				aluResult = '0;
		endcase
	end

endmodule

// File: hw/mulDivUnit.sv
`timescale 1ns/100ps

module mulDivUnit import cpuPkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  opcodeT               opcode,
	input  logic                 start,
	input  logic [DataWidth-1:0] operandA,
	input  logic [DataWidth-1:0] operandB,
	output logic                 busy,
	output logic [DataWidth-1:0] hi,
	output logic [DataWidth-1:0] lo
);

	typedef enum logic [1:0] {
		stIdle,
		stMultiplying,
		stDividing
	} stateT;

	stateT                      state;
	logic [CycleCountWidth-1:0] cyclesLeft;

	// Result waiting for the end of the busy window
	logic [DataWidth-1:0] pendingHi;
	logic [DataWidth-1:0] pendingLo;

	logic signed [2*DataWidth-1:0] signedProduct;
	logic        [2*DataWidth-1:0] unsignedProduct;
	logic signed [DataWidth-1:0]   signedQuotient;
	logic signed [DataWidth-1:0]   signedRemainder;
	logic                          divisorZero;

	//////////////////////////////////////////////////////////////////////
	// Arithmetic sampled only at start
	//////////////////////////////////////////////////////////////////////

	assign signedProduct   = $signed(operandA) * $signed(operandB);
	assign unsignedProduct = operandA * operandB;
	assign divisorZero     = (operandB == '0);

	// Signed divide results
	assign signedQuotient  = $signed(operandA) / $signed(operandB);
	assign signedRemainder = $signed(operandA) % $signed(operandB);

	// Quotient to LO and remainder to HI
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			case (opcode)
				opMult:
					{pendingHi, pendingLo} <= signedProduct;
				opMultu:
					{pendingHi, pendingLo} <= unsignedProduct;
				opDiv:
				begin
					// Zero divisor replays the old HI/LO
					pendingLo <= divisorZero ? lo : signedQuotient;
					pendingHi <= divisorZero ? hi : signedRemainder;
				end
				opDivu:
				begin
					pendingLo <= divisorZero ? lo : operandA / operandB;
					pendingHi <= divisorZero ? hi : operandA % operandB;
				end
				default:
				begin
					pendingHi <= pendingHi;
					pendingLo <= pendingLo;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Busy window and HI/LO commit
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= stIdle;
			cyclesLeft <= '0;
			hi         <= '0;
			lo         <= '0;
		end
		else if (start)
		begin
			case (opcode)
				opMult,
				opMultu:
				begin
					state      <= stMultiplying;
					cyclesLeft <= CycleCountWidth'(MultCycles);
				end
				opDiv,
				opDivu:
				begin
					state      <= stDividing;
					cyclesLeft <= CycleCountWidth'(DivCycles);
				end
				// Moves land at once without a busy window
				opMthi:
					hi <= operandA;
				opMtlo:
					lo <= operandA;
				default:
					state <= stIdle;
			endcase
		end
		else if (state != stIdle)
		begin
			cyclesLeft <= cyclesLeft - 1'b1;
			// Last busy edge commits the result
			if (cyclesLeft == CycleCountWidth'(1))
			begin
				state <= stIdle;
				hi    <= pendingHi;
				lo    <= pendingLo;
			end
		end
	end

	assign busy = (state != stIdle);

	// Decode must hold off a new op until busy drops
	noStartWhileBusy: assert property (@(posedge clk) disable iff (reset)
		start |-> state == stIdle)
		else $error("mulDivUnit: start while busy");

	// Start strobe belongs to the HI/LO class only
	startOpcodeLegal: assert property (@(posedge clk) disable iff (reset)
		start |-> opcode inside {opMult, opMultu, opDiv, opDivu, opMthi, opMtlo})
		else $error("mulDivUnit: start with opcode %s", opcode.name());

endmodule

// File: hw/exMemRegister.sv
`timescale 1ns/100ps

module exMemRegister import cpuPkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  opcodeT                      opcode,
	input  logic [DataWidth-1:0]        pc,
	input  logic [DataWidth-1:0]        aluResult,
	input  logic [DataWidth-1:0]        hi,
	input  logic [DataWidth-1:0]        lo,
	input  logic [DataWidth-1:0]        resFromId,
	input  logic [DataWidth-1:0]        storeData,
	input  logic [RegAddrWidth-1:0]     rs,
	input  logic [RegAddrWidth-1:0]     rt,
	input  logic [RegAddrWidth-1:0]     rd,
	input  logic [HazardCountWidth-1:0] tuseRsDec,
	input  logic [HazardCountWidth-1:0] tuseRtDec,
	input  logic [HazardCountWidth-1:0] tnewDec,
	output opcodeT                      opcodeMem,
	output logic [DataWidth-1:0]        pcMem,
	output logic [DataWidth-1:0]        aluOutMem,
	output logic [DataWidth-1:0]        storeDataMem,
	output logic [RegAddrWidth-1:0]     rsMem,
	output logic [RegAddrWidth-1:0]     rtMem,
	output logic [RegAddrWidth-1:0]     rdMem,
	output logic [HazardCountWidth-1:0] tuseRsMem,
	output logic [HazardCountWidth-1:0] tuseRtMem,
	output logic [HazardCountWidth-1:0] tnewMem
);

	logic [DataWidth-1:0] stageResult;

	// Value already finished in decode wins, e.g. link address
	always_comb
	begin
		if (tnewDec == '0 && rd != '0)
			stageResult = resFromId;
		else if (opcode == opMfhi)
			stageResult = hi;
		else if (opcode == opMflo)
			stageResult = lo;
		else
			stageResult = aluResult;
	end

	//////////////////////////////////////////////////////////////////////
	// EX/Mem pipeline register, no stall so loads every cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			opcodeMem    <= opNop;
			pcMem        <= ResetPc;
			aluOutMem    <= '0;
			storeDataMem <= '0;
			rsMem        <= '0;
			rtMem        <= '0;
			rdMem        <= '0;
			tuseRsMem    <= TuseIdle;
			tuseRtMem    <= TuseIdle;
			tnewMem      <= '0;
		end
		else
		begin
			opcodeMem    <= opcode;
			pcMem        <= pc;
			aluOutMem    <= stageResult;
			storeDataMem <= storeData;
			rsMem        <= rs;
			rtMem        <= rt;
			// Write-back target
			rdMem        <= rd;
			tuseRsMem    <= tuseRsDec;
			tuseRtMem    <= tuseRtDec;
			tnewMem      <= tnewDec;
		end
	end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/100ps

module executeStage import cpuPkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	// Decoded instruction
	input  opcodeT                      opcode,
	input  logic [RegAddrWidth-1:0]     rs,
	input  logic [RegAddrWidth-1:0]     rt,
	input  logic [RegAddrWidth-1:0]     rd,
	input  logic [RegAddrWidth-1:0]     shamt,
	input  logic [DataWidth-1:0]        imm32,
	input  logic [DataWidth-1:0]        rsData,
	input  logic [DataWidth-1:0]        rtData,
	input  logic [DataWidth-1:0]        resFromId,
	input  logic [DataWidth-1:0]        pc,
	input  logic [HazardCountWidth-1:0] tuseRs,
	input  logic [HazardCountWidth-1:0] tuseRt,
	input  logic [HazardCountWidth-1:0] tnew,
	// Forwarding from later stages
	input  logic [DataWidth-1:0]        bypassEx,
	input  logic [DataWidth-1:0]        bypassMem,
	input  fwdSelT                      rsFwdSel,
	input  fwdSelT                      rtFwdSel,
	input  logic                        mulDivStart,
	// EX/Mem register
	output opcodeT                      opcodeMem,
	output logic [DataWidth-1:0]        pcMem,
	output logic [DataWidth-1:0]        aluOutMem,
	output logic [DataWidth-1:0]        storeDataMem,
	output logic [RegAddrWidth-1:0]     rsMem,
	output logic [RegAddrWidth-1:0]     rtMem,
	output logic [RegAddrWidth-1:0]     rdMem,
	output logic [HazardCountWidth-1:0] tuseRsMem,
	output logic [HazardCountWidth-1:0] tuseRtMem,
	output logic [HazardCountWidth-1:0] tnewMem,
	// To the hazard unit
	output logic [RegAddrWidth-1:0]     rsEx,
	output logic [RegAddrWidth-1:0]     rtEx,
	output logic [RegAddrWidth-1:0]     rdEx,
	output logic [HazardCountWidth-1:0] tuseRsEx,
	output logic [HazardCountWidth-1:0] tuseRtEx,
	output logic [HazardCountWidth-1:0] tnewEx,
	output logic                        mulDivBusy
);

	logic [DataWidth-1:0] operandA;
	logic [DataWidth-1:0] operandB;
	logic [DataWidth-1:0] storeData;
	logic [DataWidth-1:0] aluResult;
	logic [DataWidth-1:0] hi;
	logic [DataWidth-1:0] lo;
	logic                 unitBusy;

	//////////////////////////////////////////////////////////////////////
	// Operand selection
	//////////////////////////////////////////////////////////////////////

	operandForward operandForward (
		.rsData    (rsData),
		.rtData    (rtData),
		.bypassEx  (bypassEx),
		.bypassMem (bypassMem),
		.imm32     (imm32),
		.rsFwdSel  (rsFwdSel),
		.rtFwdSel  (rtFwdSel),
		.opcode    (opcode),
		.tuseRs    (tuseRs),
		.tuseRt    (tuseRt),
		.tnew      (tnew),
		.operandA  (operandA),
		.operandB  (operandB),
		.storeData (storeData),
		.tuseRsDec (tuseRsEx),
		.tuseRtDec (tuseRtEx),
		.tnewDec   (tnewEx)
	);

	//////////////////////////////////////////////////////////////////////
	// ALU and HI/LO unit
	//////////////////////////////////////////////////////////////////////

	alu alu (
		.opcode    (opcode),
		.operandA  (operandA),
		.operandB  (operandB),
		.shamt     (shamt),
		.aluResult (aluResult)
	);

	mulDivUnit mulDivUnit (
		.clk      (clk),
		.reset    (reset),
		.opcode   (opcode),
		.start    (mulDivStart),
		.operandA (operandA),
		.operandB (operandB),
		.busy     (unitBusy),
		.hi       (hi),
		.lo       (lo)
	);

	// Busy already in the start cycle
	assign mulDivBusy = mulDivStart | unitBusy;

	//////////////////////////////////////////////////////////////////////
	// Result select and pipeline register
	//////////////////////////////////////////////////////////////////////

	exMemRegister exMemRegister (
		.clk          (clk),
		.reset        (reset),
		.opcode       (opcode),
		.pc           (pc),
		.aluResult    (aluResult),
		.hi           (hi),
		.lo           (lo),
		.resFromId    (resFromId),
		.storeData    (storeData),
		.rs           (rs),
		.rt           (rt),
		.rd           (rd),
		.tuseRsDec    (tuseRsEx),
		.tuseRtDec    (tuseRtEx),
		.tnewDec      (tnewEx),
		.opcodeMem    (opcodeMem),
		.pcMem        (pcMem),
		.aluOutMem    (aluOutMem),
		.storeDataMem (storeDataMem),
		.rsMem        (rsMem),
		.rtMem        (rtMem),
		.rdMem        (rdMem),
		.tuseRsMem    (tuseRsMem),
		.tuseRtMem    (tuseRtMem),
		.tnewMem      (tnewMem)
	);

	// Register addresses seen by the hazard unit
	assign rsEx = rs;
	assign rtEx = rt;
	assign rdEx = rd;

endmodule

// File: bench/executeStageTb.sv
`timescale 1ns/100ps

module executeStageTb import cpuPkg::*;
();

	localparam int BusyTimeout = 40;
	localparam int MaxLines = 256;
	localparam int FieldCount = 21;
	localparam logic [31:0] Seed = 32'h0b51_30f6;

	// DUT inputs
	logic                        clk;
	logic                        reset;
	opcodeT                      opcode;
	logic [RegAddrWidth-1:0]     rs;
	logic [RegAddrWidth-1:0]     rt;
	logic [RegAddrWidth-1:0]     rd;
	logic [RegAddrWidth-1:0]     shamt;
	logic [DataWidth-1:0]        imm32;
	logic [DataWidth-1:0]        rsData;
	logic [DataWidth-1:0]        rtData;
	logic [DataWidth-1:0]        resFromId;
	logic [DataWidth-1:0]        pc;
	logic [HazardCountWidth-1:0] tuseRs;
	logic [HazardCountWidth-1:0] tuseRt;
	logic [HazardCountWidth-1:0] tnew;
	logic [DataWidth-1:0]        bypassEx;
	logic [DataWidth-1:0]        bypassMem;
	fwdSelT                      rsFwdSel;
	fwdSelT                      rtFwdSel;
	logic                        mulDivStart;

	// DUT outputs
	opcodeT                      opcodeMem;
	logic [DataWidth-1:0]        pcMem;
	logic [DataWidth-1:0]        aluOutMem;
	logic [DataWidth-1:0]        storeDataMem;
	logic [RegAddrWidth-1:0]     rsMem;
	logic [RegAddrWidth-1:0]     rtMem;
	logic [RegAddrWidth-1:0]     rdMem;
	logic [HazardCountWidth-1:0] tuseRsMem;
	logic [HazardCountWidth-1:0] tuseRtMem;
	logic [HazardCountWidth-1:0] tnewMem;
	logic [RegAddrWidth-1:0]     rsEx;
	logic [RegAddrWidth-1:0]     rtEx;
	logic [RegAddrWidth-1:0]     rdEx;
	logic [HazardCountWidth-1:0] tuseRsEx;
	logic [HazardCountWidth-1:0] tuseRtEx;
	logic [HazardCountWidth-1:0] tnewEx;
	logic                        mulDivBusy;

	// One golden line in file column order
	logic [31:0] vecId, vecOp, vecRsSel, vecRtSel, vecRs, vecRt, vecRd;
	logic [31:0] vecShamt, vecTnew, vecTuseRs, vecTuseRt, vecPc, vecRsData;
	logic [31:0] vecRtData, vecImm, vecBypEx, vecBypMem, vecResId, vecStart;
	logic [31:0] expAlu, expStore;

	int          errorCount;
	int          testCount;
	logic        timedOut;

	executeStage UUT (.*);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Checking helpers
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, want);
		errorCount++;
	endtask

	// Count one stage later with a floor at zero
	function automatic logic [HazardCountWidth-1:0] expectedCount(input logic [31:0] count);
		if (count == 0)
			return '0;
		return HazardCountWidth'(count - 1);
	endfunction

	task automatic checkResetState();
		int errorsBefore;
		errorsBefore = errorCount;
		if (opcodeMem !== opNop)
			reportMismatch("opcodeMem", opcodeMem, opNop);
		if (pcMem !== 32'h0000_3000)
			reportMismatch("pcMem", pcMem, 32'h0000_3000);
		if (tuseRsMem !== 3'd7)
			reportMismatch("tuseRsMem", tuseRsMem, 3'd7);
		if (tuseRtMem !== 3'd7)
			reportMismatch("tuseRtMem", tuseRtMem, 3'd7);
		if (tnewMem !== 3'd0)
			reportMismatch("tnewMem", tnewMem, 3'd0);
		if (mulDivBusy !== 1'b0)
			reportMismatch("mulDivBusy", mulDivBusy, 1'b0);
		testCount++;
		$display("test reset: %s", (errorCount == errorsBefore) ? "ok" : "failed");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic applyVector();
		fwdSelT rsSel;
		fwdSelT rtSel;
		opcodeT op;
		rsSel = fwdSelT'(vecRsSel[1:0]);
		rtSel = fwdSelT'(vecRtSel[1:0]);
		op = opcodeT'(vecOp[4:0]);
		opcode      <= op;
		rsFwdSel    <= rsSel;
		rtFwdSel    <= rtSel;
		rs          <= vecRs[4:0];
		rt          <= vecRt[4:0];
		rd          <= vecRd[4:0];
		tnew        <= vecTnew[2:0];
		tuseRs      <= vecTuseRs[2:0];
		tuseRt      <= vecTuseRt[2:0];
		pc          <= vecPc;
		imm32       <= vecImm;
		resFromId   <= vecResId;
		mulDivStart <= vecStart[0];
		// Sources the selects ignore get noise
		if (rsSel == fwdRegFile)
			rsData <= vecRsData;
		else
			rsData <= $urandom();
		if (rtSel == fwdRegFile)
			rtData <= vecRtData;
		else
			rtData <= $urandom();
		if (rsSel == fwdEx || rtSel == fwdEx)
			bypassEx <= vecBypEx;
		else
			bypassEx <= $urandom();
		if (rsSel == fwdMem || rtSel == fwdMem)
			bypassMem <= vecBypMem;
		else
			bypassMem <= $urandom();
		// Only the fixed shifts read shamt
		if (op inside {opSll, opSrl, opSra})
			shamt <= vecShamt[4:0];
		else
			shamt <= RegAddrWidth'($urandom());
	endtask

	// Nop between vectors without start
	task automatic driveBubble();
		opcode      <= opNop;
		mulDivStart <= 1'b0;
		rd          <= '0;
		tnew        <= '0;
	endtask

	task automatic waitBusyLow(input int expectedCycles);
		int cycles;
		cycles = 0;
		while (mulDivBusy && cycles < BusyTimeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (mulDivBusy)
		begin
			$display("mulDivBusy never cleared within %0d cycles", BusyTimeout);
			errorCount++;
			timedOut = 1'b1;
		end
		else if (cycles != expectedCycles)
			reportMismatch("mulDivBusy cycles", cycles, expectedCycles);
	endtask

	task automatic runVector();
		int     errorsBefore;
		int     busyCycles;
		opcodeT op;
		errorsBefore = errorCount;
		op = opcodeT'(vecOp[4:0]);
		@(posedge clk);
		applyVector();
		// Hazard outputs follow the inputs at once
		@(negedge clk);
		if (rsEx !== vecRs[4:0])
			reportMismatch("rsEx", rsEx, vecRs);
		if (rtEx !== vecRt[4:0])
			reportMismatch("rtEx", rtEx, vecRt);
		if (rdEx !== vecRd[4:0])
			reportMismatch("rdEx", rdEx, vecRd);
		if (tuseRsEx !== expectedCount(vecTuseRs))
			reportMismatch("tuseRsEx", tuseRsEx, expectedCount(vecTuseRs));
		if (tuseRtEx !== expectedCount(vecTuseRt))
			reportMismatch("tuseRtEx", tuseRtEx, expectedCount(vecTuseRt));
		if (tnewEx !== expectedCount(vecTnew))
			reportMismatch("tnewEx", tnewEx, expectedCount(vecTnew));
		if (mulDivBusy !== vecStart[0])
			reportMismatch("mulDivBusy", mulDivBusy, vecStart[0]);
		// EX/Mem copy one edge later
		@(posedge clk);
		driveBubble();
		@(negedge clk);
		if (opcodeMem !== op)
			reportMismatch("opcodeMem", opcodeMem, op);
		if (pcMem !== vecPc)
			reportMismatch("pcMem", pcMem, vecPc);
		if (aluOutMem !== expAlu)
			reportMismatch("aluOutMem", aluOutMem, expAlu);
		if (storeDataMem !== expStore)
			reportMismatch("storeDataMem", storeDataMem, expStore);
		if (rsMem !== vecRs[4:0])
			reportMismatch("rsMem", rsMem, vecRs);
		if (rtMem !== vecRt[4:0])
			reportMismatch("rtMem", rtMem, vecRt);
		if (rdMem !== vecRd[4:0])
			reportMismatch("rdMem", rdMem, vecRd);
		if (tuseRsMem !== expectedCount(vecTuseRs))
			reportMismatch("tuseRsMem", tuseRsMem, expectedCount(vecTuseRs));
		if (tuseRtMem !== expectedCount(vecTuseRt))
			reportMismatch("tuseRtMem", tuseRtMem, expectedCount(vecTuseRt));
		if (tnewMem !== expectedCount(vecTnew))
			reportMismatch("tnewMem", tnewMem, expectedCount(vecTnew));
		// Fixed latency per class and none for moves
		if (vecStart[0])
		begin
			case (op)
				opMult, opMultu: busyCycles = MultCycles;
				opDiv, opDivu:   busyCycles = DivCycles;
				default:         busyCycles = 0;
			endcase
			waitBusyLow(busyCycles);
		end
		testCount++;
		$display("test %0d %s: %s", vecId, op.name(),
			(errorCount == errorsBefore) ? "ok" : "failed");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int    fd;
		int    lineNumber;
		int    readStatus;
		int    fieldsRead;
		string line;
		errorCount = 0;
		testCount = 0;
		timedOut = 1'b0;
		void'($urandom(Seed));
		clk = 1'b0;
		reset = 1'b1;
		opcode = opNop;
		rs = '0;
		rt = '0;
		rd = '0;
		shamt = '0;
		imm32 = '0;
		rsData = '0;
		rtData = '0;
		resFromId = '0;
		pc = '0;
		tuseRs = '0;
		tuseRt = '0;
		tnew = '0;
		bypassEx = '0;
		bypassMem = '0;
		rsFwdSel = fwdRegFile;
		rtFwdSel = fwdRegFile;
		mulDivStart = 1'b0;
		fd = $fopen("bench/executeGolden.hex", "r");
		if (fd == 0)
		begin
			$display("Could not open bench/executeGolden.hex");
			errorCount++;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkResetState();
		lineNumber = 0;
		while (fd != 0 && !timedOut && !$feof(fd) && lineNumber < MaxLines)
		begin
			lineNumber++;
			readStatus = $fgets(line, fd);
			if (readStatus != 0)
			begin
				fieldsRead = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					vecId, vecOp, vecRsSel, vecRtSel, vecRs, vecRt, vecRd, vecShamt,
					vecTnew, vecTuseRs, vecTuseRt, vecPc, vecRsData, vecRtData, vecImm,
					vecBypEx, vecBypMem, vecResId, vecStart, expAlu, expStore);
				// Comment and blank lines parse to nothing
				if (fieldsRead == FieldCount)
					runVector();
				else if (fieldsRead > 0)
				begin
					$display("Golden line %0d holds %0d fields, not %0d",
						lineNumber, fieldsRead, FieldCount);
					errorCount++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (testCount < 2)
		begin
			$display("No vectors were read from the golden file");
			errorCount++;
		end
		$display("Summary: %0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: bench/executeGolden.hex
// id op rsSel rtSel rs rt rd shamt tnew tuseRs tuseRt pc rsData rtData imm32
// bypassEx bypassMem resFromId start expAluOutMem expStoreDataMem, all hex
01 01 0 0 01 02 03 00 2 1 1 3000 7fffffff 00000001 0 0 0 0 0 80000000 00000001
02 02 0 0 04 05 06 00 2 1 1 3004 00000003 00000005 0 0 0 0 0 fffffffe 00000005
03 03 0 0 07 08 09 00 2 1 1 3008 a5a5f00f 0ff00ff0 0 0 0 0 0 05a00000 0ff00ff0
04 04 0 0 0a 0b 0c 00 2 1 1 300c 12340000 00005678 0 0 0 0 0 12345678 00005678
05 05 0 0 0d 0e 0f 00 2 1 1 3010 ffff0000 0f0f0f0f 0 0 0 0 0 f0f00f0f 0f0f0f0f
06 06 0 0 10 11 12 00 2 1 1 3014 f0f0f0f0 0000ffff 0 0 0 0 0 0f0f0000 0000ffff
07 07 0 0 13 14 15 00 2 1 1 3018 fffffffe 00000003 0 0 0 0 0 00000001 00000003
08 08 0 0 13 14 15 00 2 1 1 301c fffffffe 00000003 0 0 0 0 0 00000000 00000003
09 09 0 0 00 16 17 04 2 7 1 3020 12345678 80000001 0 0 0 0 0 00000010 80000001
0a 0a 0 0 00 16 17 04 2 7 1 3024 12345678 80000001 0 0 0 0 0 08000000 80000001
0b 0b 0 0 00 16 17 04 2 7 1 3028 12345678 80000001 0 0 0 0 0 f8000000 80000001
0c 0c 0 0 18 19 1a 00 2 1 1 302c 00000024 00000003 0 0 0 0 0 00000030 00000003
0d 0d 0 0 00 1b 1b 00 2 7 7 3030 0 11111111 0000abcd 0 0 0 0 abcd0000 11111111
0e 0e 0 0 1c 1d 1d 00 2 1 7 3034 12340000 22222222 0000ffff 0 0 0 0 1234ffff 22222222
0f 0f 0 0 1e 01 01 00 2 1 7 3038 00000100 33333333 fffffff0 0 0 0 0 000000f0 33333333
10 10 0 0 1d 02 02 00 3 1 7 303c 00001000 55555555 00000004 0 0 0 0 00001004 55555555
11 11 0 0 1d 03 00 00 0 1 2 3040 00001000 44444444 fffffffc 0 0 0 0 00000ffc 44444444
12 01 1 2 04 05 06 00 2 1 1 3044 0 0 0 00000100 00000023 0 0 00000123 00000023
13 02 2 1 04 05 06 00 2 1 1 3048 0 0 0 00000010 00000050 0 0 00000040 00000010
14 11 0 1 07 08 00 00 0 1 2 304c 00002000 0 00000008 cafef00d 0 0 0 00002008 cafef00d
15 0f 2 2 09 0a 0a 00 2 1 1 3050 0 0 00000003 0 00000005 0 0 00000008 00000005
16 18 0 0 0b 00 00 00 0 1 7 3054 0000beef 0 0 0 0 0 1 00000000 00000000
17 19 0 0 0c 00 00 00 0 1 7 3058 0000cafe 0 0 0 0 0 1 00000000 00000000
18 16 0 0 00 00 05 00 2 7 7 305c 0 0 0 0 0 0 0 0000beef 00000000
19 17 0 0 00 00 06 00 2 7 7 3060 0 0 0 0 0 0 0 0000cafe 00000000
1a 12 0 0 01 02 00 00 0 1 1 3064 fffffffd 00000007 0 0 0 0 1 00000000 00000007
1b 16 0 0 00 00 05 00 2 7 7 3068 0 0 0 0 0 0 0 ffffffff 00000000
1c 17 0 0 00 00 06 00 2 7 7 306c 0 0 0 0 0 0 0 ffffffeb 00000000
1d 13 0 0 01 02 00 00 0 1 1 3070 ffffffff 00000002 0 0 0 0 1 00000000 00000002
1e 16 0 0 00 00 05 00 2 7 7 3074 0 0 0 0 0 0 0 00000001 00000000
1f 17 0 0 00 00 06 00 2 7 7 3078 0 0 0 0 0 0 0 fffffffe 00000000
20 14 0 0 01 02 00 00 0 1 1 307c fffffff9 00000002 0 0 0 0 1 00000000 00000002
21 16 0 0 00 00 05 00 2 7 7 3080 0 0 0 0 0 0 0 ffffffff 00000000
22 17 0 0 00 00 06 00 2 7 7 3084 0 0 0 0 0 0 0 fffffffd 00000000
23 15 0 0 01 02 00 00 0 1 1 3088 00000064 00000007 0 0 0 0 1 00000000 00000007
24 16 0 0 00 00 05 00 2 7 7 308c 0 0 0 0 0 0 0 00000002 00000000
25 17 0 0 00 00 06 00 2 7 7 3090 0 0 0 0 0 0 0 0000000e 00000000
26 14 0 0 01 02 00 00 0 1 1 3094 00001234 00000000 0 0 0 0 1 00000000 00000000
27 16 0 0 00 00 05 00 2 7 7 3098 0 0 0 0 0 0 0 00000002 00000000
28 17 0 0 00 00 06 00 2 7 7 309c 0 0 0 0 0 0 0 0000000e 00000000
29 1a 0 0 00 00 1f 00 1 0 0 30a0 0 0 0 0 0 000030a8 0 000030a8 00000000

// File: compile.f
hw/cpuPkg.sv
hw/operandForward.sv
hw/alu.sv
hw/mulDivUnit.sv
hw/exMemRegister.sv
hw/executeStage.sv
bench/executeStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
BINARY=simExecuteStage

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module executeStageTb \
	-Mdir "$BUILD_DIR" -o "$BINARY"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$BINARY" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
	exit 0
fi
echo "Testbench reported failures, see $LOG"
exit 1
